/* design/nfcProgram_consts.svh */
`ifndef NFC_PROGRAM_CONSTS_SVH
`define NFC_PROGRAM_CONSTS_SVH

// opcode on the command strobe that selects program page
`define NFC_PROGRAM_COMMAND_ID          6'b000011

// NAND opcodes of the program page sequence
`define NFC_OPCODE_PROGRAM              8'h80
`define NFC_OPCODE_CONFIRM              8'h10
`define NFC_OPCODE_CONFIRM_CACHE        8'h15
`define NFC_OPCODE_CONFIRM_MULTIPLANE   8'h11

// submodule select bits
// same position in the command byte and in the last-step vector
`define NFC_ACG_COMMAND_CA              3
`define NFC_ACG_COMMAND_DATA            2

// data count field during the address phase
`define NFC_ADDRESS_COUNT               16'd4

`endif

/* design/nfcProgramPkg.sv */
package nfcProgramPkg;

    // fields of one accepted program command
    typedef struct packed {
        logic [4:0]  targetId;
        logic [15:0] length;
        logic [15:0] colAddress;
        logic [23:0] rowAddress;
    } programCommandT;

    // request handed to the command/address and data submodules
    typedef struct packed {
        logic [7:0]  command;
        logic [15:0] numOfData;
        logic        caSelect;
        logic [39:0] caData;
    } acgRequestT;

    // steps of the program page operation
    typedef enum logic [2:0] {
        idle         = 3'd0,
        latch        = 3'd1,
        cmdIssue     = 3'd2,
        addrIssue    = 3'd3,
        dataIssue    = 3'd4,
        confirmIssue = 3'd5,
        confirmDone  = 3'd6
    } programStepT;

endpackage

/* design/programCommandLatch.sv */
`include "nfcProgram_consts.svh"

module programCommandLatch #(
    parameter int NumberOfWays = 4
) (
    input  logic                          iSystemClock,
    input  logic                          iReset,
    input  nfcProgramPkg::programStepT    iNextStep,
    input  nfcProgramPkg::programCommandT iCommand,
    input  logic [NumberOfWays-1:0]       iWaySelect,
    output logic [39:0]                   oAddressBytes,
    output logic [7:0]                    oConfirmOpcode,
    output logic [15:0]                   oLength,
    output logic [NumberOfWays-1:0]       oTargetWay
);

    import nfcProgramPkg::*;

    programCommandT commandReg;
    logic           captureCommand;

    // capture happens on the accepting edge only
    assign captureCommand = (iNextStep == latch);

    // command fields held until the next acceptance
    always_ff @(posedge iSystemClock) begin
        if (captureCommand) begin
            commandReg <= iCommand;
        end
    end

    // target way held together with the command
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oTargetWay <= '0;
        end else if (captureCommand) begin
            oTargetWay <= iWaySelect;
        end
    end

    // five address cycles with column first and low byte first
    assign oAddressBytes = {commandReg.colAddress[7:0],
                            commandReg.colAddress[15:8],
                            commandReg.rowAddress[7:0],
                            commandReg.rowAddress[15:8],
                            commandReg.rowAddress[23:16]};

    // target bits 1..0 pick the program flavour
    always_comb begin
        case (commandReg.targetId[1:0])
            2'b01:   oConfirmOpcode = `NFC_OPCODE_CONFIRM_CACHE;
            2'b10:   oConfirmOpcode = `NFC_OPCODE_CONFIRM_MULTIPLANE;
            default: oConfirmOpcode = `NFC_OPCODE_CONFIRM;
        endcase
    end

    assign oLength = commandReg.length;

endmodule

/* design/programStepSequencer.sv */
`include "nfcProgram_consts.svh"

module programStepSequencer (
    input  logic                       iSystemClock,
    input  logic                       iReset,
    input  logic [5:0]                 iOpcode,
    input  logic                       iCMDValid,
    input  logic [7:0]                 iACG_LastStep,
    output nfcProgramPkg::programStepT oNextStep,
    output logic                       oCMDReady,
    output logic                       oStart,
    output logic                       oLastStep
);

    import nfcProgramPkg::*;

    programStepT currentStep;
    programStepT nextStep;
    logic        caLastStep;
    logic        dataLastStep;
    logic        accept;

    // strobe decode, independent of whether we are busy
    assign oStart = iCMDValid && (iOpcode == `NFC_PROGRAM_COMMAND_ID);

    // a strobe while busy is simply dropped
    assign accept = oStart && oCMDReady;

    assign caLastStep   = iACG_LastStep[`NFC_ACG_COMMAND_CA];
    assign dataLastStep = iACG_LastStep[`NFC_ACG_COMMAND_DATA];

    // each issue step waits on the last step of its own submodule
    always_comb begin
        nextStep = currentStep;
        case (currentStep)
            idle: begin
                if (accept) begin
                    nextStep = latch;
                end
            end
            latch: begin
                nextStep = cmdIssue;
            end
            cmdIssue: begin
                if (caLastStep) begin
                    nextStep = addrIssue;
                end
            end
            addrIssue: begin
                if (caLastStep) begin
                    nextStep = dataIssue;
                end
            end
            dataIssue: begin
                if (dataLastStep) begin
                    nextStep = confirmIssue;
                end
            end
            confirmIssue: begin
                if (caLastStep) begin
                    nextStep = confirmDone;
                end
            end
            confirmDone: begin
                nextStep = idle;
            end
            default: begin
                nextStep = idle;
            end
        endcase
    end

    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            currentStep <= idle;
        end else begin
            currentStep <= nextStep;
        end
    end

    // registered from the next step so they line up with currentStep
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oCMDReady <= 1'b1;
            oLastStep <= 1'b0;
        end else begin
            oCMDReady <= (nextStep == idle);
            oLastStep <= (nextStep == confirmDone);
        end
    end

    assign oNextStep = nextStep;

endmodule

/* design/acgRequestBuilder.sv */
`include "nfcProgram_consts.svh"

module acgRequestBuilder (
    input  logic                       iSystemClock,
    input  logic                       iReset,
    input  nfcProgramPkg::programStepT iNextStep,
    input  logic [39:0]                iAddressBytes,
    input  logic [7:0]                 iConfirmOpcode,
    input  logic [15:0]                iLength,
    output nfcProgramPkg::acgRequestT  oRequest
);

    import nfcProgramPkg::*;

    // one-hot submodule select bytes
    localparam logic [7:0] caCommand   = 8'(1) << `NFC_ACG_COMMAND_CA;
    localparam logic [7:0] dataCommand = 8'(1) << `NFC_ACG_COMMAND_DATA;

    // nothing requested, CA select parked high
    localparam acgRequestT idleRequest = '{
        command:   8'h00,
        numOfData: 16'h0000,
        caSelect:  1'b1,
        caData:    40'h00_0000_0000
    };

    acgRequestT stepRequest;

    always_comb begin
        stepRequest = idleRequest;
        case (iNextStep)
            cmdIssue: begin
                // first opcode, CA select high marks a command cycle
                stepRequest.command  = caCommand;
                stepRequest.caSelect = 1'b1;
                stepRequest.caData   = {`NFC_OPCODE_PROGRAM, 32'h0000_0000};
            end
            addrIssue: begin
                stepRequest.command   = caCommand;
                stepRequest.caSelect  = 1'b0;
                stepRequest.numOfData = `NFC_ADDRESS_COUNT;
                stepRequest.caData    = iAddressBytes;
            end
            dataIssue: begin
                stepRequest.command   = dataCommand;
                stepRequest.caSelect  = 1'b0;
                stepRequest.numOfData = iLength;
            end
            confirmIssue: begin
                stepRequest.command  = caCommand;
                stepRequest.caSelect = 1'b1;
                stepRequest.caData   = {iConfirmOpcode, 32'h0000_0000};
            end
            default: begin
                // idle, latch and confirmDone issue nothing
                stepRequest = idleRequest;
            end
        endcase
    end

    // request stays put while a phase waits for its last step
    always_ff @(posedge iSystemClock or posedge iReset) begin
        if (iReset) begin
            oRequest <= idleRequest;
        end else begin
            oRequest <= stepRequest;
        end
    end

endmodule

/* design/nfcProgramPage.sv */
module nfcProgramPage #(
    parameter int NumberOfWays = 4
) (
    input  logic                    iSystemClock,
    input  logic                    iReset,

    // command strobe
    input  logic [5:0]              iOpcode,
    input  logic [4:0]              iTargetID,
    input  logic [15:0]             iLength,
    input  logic [15:0]             iColAddress,
    input  logic [23:0]             iRowAddress,
    input  logic                    iCMDValid,
    input  logic [NumberOfWays-1:0] iWaySelect,
    output logic                    oCMDReady,
    output logic                    oStart,
    output logic                    oLastStep,

    // submodule side
    input  logic [7:0]              iACG_LastStep,
    output logic [7:0]              oACG_Command,
    output logic [15:0]             oACG_NumOfData,
    output logic                    oACG_CASelect,
    output logic [39:0]             oACG_CAData,
    output logic [NumberOfWays-1:0] oACG_TargetWay
);

    import nfcProgramPkg::*;

    programCommandT command;
    programStepT    nextStep;
    acgRequestT     request;
    logic [39:0]    addressBytes;
    logic [7:0]     confirmOpcode;
    logic [15:0]    latchedLength;

    assign command = '{
        targetId:   iTargetID,
        length:     iLength,
        colAddress: iColAddress,
        rowAddress: iRowAddress
    };

    programStepSequencer stepSequencer (
        .iSystemClock  (iSystemClock),
        .iReset        (iReset),
        .iOpcode       (iOpcode),
        .iCMDValid     (iCMDValid),
        .iACG_LastStep (iACG_LastStep),
        .oNextStep     (nextStep),
        .oCMDReady     (oCMDReady),
        .oStart        (oStart),
        .oLastStep     (oLastStep)
    );

    programCommandLatch #(
        .NumberOfWays (NumberOfWays)
    ) commandLatch (
        .iSystemClock   (iSystemClock),
        .iReset         (iReset),
        .iNextStep      (nextStep),
        .iCommand       (command),
        .iWaySelect     (iWaySelect),
        .oAddressBytes  (addressBytes),
        .oConfirmOpcode (confirmOpcode),
        .oLength        (latchedLength),
        .oTargetWay     (oACG_TargetWay)
    );

    acgRequestBuilder requestBuilder (
        .iSystemClock   (iSystemClock),
        .iReset         (iReset),
        .iNextStep      (nextStep),
        .iAddressBytes  (addressBytes),
        .iConfirmOpcode (confirmOpcode),
        .iLength        (latchedLength),
        .oRequest       (request)
    );

    assign oACG_Command   = request.command;
    assign oACG_NumOfData = request.numOfData;
    assign oACG_CASelect  = request.caSelect;
    assign oACG_CAData    = request.caData;

endmodule

/* dv/nfcProgramPage_props.sv */
`include "nfcProgram_consts.svh"

module nfcProgramPageProps #(
    parameter int NumberOfWays = 4
) (
    input logic                    iSystemClock,
    input logic                    iReset,
    input logic [5:0]              iOpcode,
    input logic [4:0]              iTargetID,
    input logic [15:0]             iLength,
    input logic [15:0]             iColAddress,
    input logic [23:0]             iRowAddress,
    input logic                    iCMDValid,
    input logic [NumberOfWays-1:0] iWaySelect,
    input logic                    oCMDReady,
    input logic                    oStart,
    input logic                    oLastStep,
    input logic [7:0]              iACG_LastStep,
    input logic [7:0]              oACG_Command,
    input logic [15:0]             oACG_NumOfData,
    input logic                    oACG_CASelect,
    input logic [39:0]             oACG_CAData,
    input logic [NumberOfWays-1:0] oACG_TargetWay
);

    localparam logic [7:0] caCommand   = 8'd1 << `NFC_ACG_COMMAND_CA;
    localparam logic [7:0] dataCommand = 8'd1 << `NFC_ACG_COMMAND_DATA;

    int                      errorCount = 0;
    logic [1:0]              capturedPlane;
    logic [15:0]             capturedLength;
    logic [15:0]             capturedCol;
    logic [23:0]             capturedRow;
    logic [NumberOfWays-1:0] capturedWay;
    logic [64:0]             requestBits;
    logic [64:0]             previousRequest;
    logic [39:0]             expectedAddress;
    logic [7:0]              expectedConfirm;
    logic                    accepted;
    logic                    wrongStrobe;
    logic                    caLast;
    logic                    dataLast;
    logic                    caRequest;
    logic                    cmdPhase;
    logic                    addrPhase;
    logic                    dataPhase;
    logic                    confirmPhase;

    assign accepted     = oStart && oCMDReady;
    assign wrongStrobe  = iCMDValid && (iOpcode != `NFC_PROGRAM_COMMAND_ID);
    assign caLast       = iACG_LastStep[`NFC_ACG_COMMAND_CA];
    assign dataLast     = iACG_LastStep[`NFC_ACG_COMMAND_DATA];
    assign requestBits  = {oACG_Command, oACG_NumOfData, oACG_CASelect, oACG_CAData};
    assign caRequest    = (oACG_Command == caCommand);
    assign cmdPhase     = caRequest && oACG_CASelect
                          && (oACG_CAData[39:32] == `NFC_OPCODE_PROGRAM);
    assign addrPhase    = caRequest && !oACG_CASelect;
    assign dataPhase    = (oACG_Command == dataCommand) && !oACG_CASelect
                          && (oACG_CAData == 40'h0);
    assign confirmPhase = caRequest && oACG_CASelect
                          && (oACG_CAData[39:32] != `NFC_OPCODE_PROGRAM);

    // column low, column high, then row low to high
    assign expectedAddress = {capturedCol[7:0], capturedCol[15:8],
                              capturedRow[7:0], capturedRow[15:8], capturedRow[23:16]};

    always_comb begin
        case (capturedPlane)
            2'b01:   expectedConfirm = `NFC_OPCODE_CONFIRM_CACHE;
            2'b10:   expectedConfirm = `NFC_OPCODE_CONFIRM_MULTIPLANE;
            default: expectedConfirm = `NFC_OPCODE_CONFIRM;
        endcase
    end

    // own copy of the accepted fields
    always_ff @(posedge iSystemClock) begin
        if (accepted) begin
            capturedPlane  <= iTargetID[1:0];
            capturedLength <= iLength;
            capturedCol    <= iColAddress;
            capturedRow    <= iRowAddress;
            capturedWay    <= iWaySelect;
        end
        previousRequest <= requestBits;
    end

    assert property (@(posedge iSystemClock) (!iReset && $past(iReset)) |->
        (oCMDReady && !oLastStep && oACG_Command == 8'h00 && oACG_CASelect))
    else begin
        errorCount++;
        $error("[FAIL] %0t reset outputs expected ready 1 last 0 cmd 00 sel 1 got %b %b %h %b",
            $time, $sampled(oCMDReady), $sampled(oLastStep), $sampled(oACG_Command),
            $sampled(oACG_CASelect));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        wrongStrobe |-> !oStart)
    else begin
        errorCount++;
        $error("[FAIL] %0t oStart expected 0 got %b", $time, $sampled(oStart));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        (wrongStrobe && oCMDReady) |=> oCMDReady)
    else begin
        errorCount++;
        $error("[FAIL] %0t oCMDReady expected 1 got %b", $time, $sampled(oCMDReady));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        accepted |=> !oCMDReady)
    else begin
        errorCount++;
        $error("[FAIL] %0t oCMDReady expected 0 got %b", $time, $sampled(oCMDReady));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        $past(accepted, 2) |-> cmdPhase)
    else begin
        errorCount++;
        $error("[FAIL] %0t oACG_CAData top byte expected %h got %h (cmd %h)", $time,
            `NFC_OPCODE_PROGRAM, $sampled(oACG_CAData[39:32]), $sampled(oACG_Command));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        (caLast && cmdPhase) |=>
        (addrPhase && oACG_NumOfData == `NFC_ADDRESS_COUNT && oACG_CAData == expectedAddress))
    else begin
        errorCount++;
        $error("[FAIL] %0t oACG_CAData expected %h got %h (count %0d)", $time,
            $sampled(expectedAddress), $sampled(oACG_CAData), $sampled(oACG_NumOfData));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        (caLast && addrPhase) |=> (dataPhase && oACG_NumOfData == capturedLength))
    else begin
        errorCount++;
        $error("[FAIL] %0t oACG_NumOfData expected %h got %h (cmd %h)", $time,
            $sampled(capturedLength), $sampled(oACG_NumOfData), $sampled(oACG_Command));
    end

    // a phase holds its request until its own last step
    assert property (@(posedge iSystemClock) disable iff (iReset)
        (oACG_Command != 8'h00 && !caLast && !dataLast) |=> (requestBits == previousRequest))
    else begin
        errorCount++;
        $error("[FAIL] %0t request expected %h got %h", $time,
            $sampled(previousRequest), $sampled(requestBits));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        (dataLast && dataPhase) |=> (confirmPhase && oACG_CAData[39:32] == expectedConfirm))
    else begin
        errorCount++;
        $error("[FAIL] %0t confirm opcode expected %h got %h", $time,
            $sampled(expectedConfirm), $sampled(oACG_CAData[39:32]));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        (caLast && confirmPhase) |=> (oLastStep && oACG_Command == 8'h00))
    else begin
        errorCount++;
        $error("[FAIL] %0t oLastStep/oACG_Command expected 1/00 got %b/%h", $time,
            $sampled(oLastStep), $sampled(oACG_Command));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        oLastStep |=> (!oLastStep && oCMDReady))
    else begin
        errorCount++;
        $error("[FAIL] %0t oLastStep/oCMDReady expected 0/1 got %b/%b", $time,
            $sampled(oLastStep), $sampled(oCMDReady));
    end

    assert property (@(posedge iSystemClock) disable iff (iReset)
        !oCMDReady |-> (oACG_TargetWay == capturedWay))
    else begin
        errorCount++;
        $error("[FAIL] %0t oACG_TargetWay expected %b got %b", $time,
            $sampled(capturedWay), $sampled(oACG_TargetWay));
    end

endmodule

bind nfcProgramPage nfcProgramPageProps #(
    .NumberOfWays (NumberOfWays)
) propertyChecks (
    .iSystemClock   (iSystemClock),
    .iReset         (iReset),
    .iOpcode        (iOpcode),
    .iTargetID      (iTargetID),
    .iLength        (iLength),
    .iColAddress    (iColAddress),
    .iRowAddress    (iRowAddress),
    .iCMDValid      (iCMDValid),
    .iWaySelect     (iWaySelect),
    .oCMDReady      (oCMDReady),
    .oStart         (oStart),
    .oLastStep      (oLastStep),
    .iACG_LastStep  (iACG_LastStep),
    .oACG_Command   (oACG_Command),
    .oACG_NumOfData (oACG_NumOfData),
    .oACG_CASelect  (oACG_CASelect),
    .oACG_CAData    (oACG_CAData),
    .oACG_TargetWay (oACG_TargetWay)
);

/* dv/tbNfcProgramPage.sv */
`include "nfcProgram_consts.svh"

module tbNfcProgramPage;

    localparam int NumberOfWays = 4;
    localparam int CommandCount = 12;
    // 12 commands at about 40 cycles each plus reset and margin
    localparam int CycleLimit   = 600;

    logic                    iSystemClock = 1'b0;
    logic                    iReset;
    logic [5:0]              iOpcode;
    logic [4:0]              iTargetID;
    logic [15:0]             iLength;
    logic [15:0]             iColAddress;
    logic [23:0]             iRowAddress;
    logic                    iCMDValid;
    logic [NumberOfWays-1:0] iWaySelect;
    logic [7:0]              iACG_LastStep;
    logic                    oCMDReady;
    logic                    oStart;
    logic                    oLastStep;
    logic [7:0]              oACG_Command;
    logic [15:0]             oACG_NumOfData;
    logic                    oACG_CASelect;
    logic [39:0]             oACG_CAData;
    logic [NumberOfWays-1:0] oACG_TargetWay;

    int seed         = 32'hd821;
    int responseSeed = 32'hd821;
    int cycleCount   = 0;
    int timeoutCount = 0;

    always #2 iSystemClock = ~iSystemClock;

    nfcProgramPage #(
        .NumberOfWays (NumberOfWays)
    ) UUT (
        .iSystemClock   (iSystemClock),
        .iReset         (iReset),
        .iOpcode        (iOpcode),
        .iTargetID      (iTargetID),
        .iLength        (iLength),
        .iColAddress    (iColAddress),
        .iRowAddress    (iRowAddress),
        .iCMDValid      (iCMDValid),
        .iWaySelect     (iWaySelect),
        .oCMDReady      (oCMDReady),
        .oStart         (oStart),
        .oLastStep      (oLastStep),
        .iACG_LastStep  (iACG_LastStep),
        .oACG_Command   (oACG_Command),
        .oACG_NumOfData (oACG_NumOfData),
        .oACG_CASelect  (oACG_CASelect),
        .oACG_CAData    (oACG_CAData),
        .oACG_TargetWay (oACG_TargetWay)
    );

    task automatic finishRun();
        $display("assertion errors %0d, timeouts %0d",
            UUT.propertyChecks.errorCount, timeoutCount);
        if (UUT.propertyChecks.errorCount == 0 && timeoutCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // strobes with an opcode other than program page
    task automatic sendWrongStrobes();
        logic [31:0] randomWord;
        int          strobes;
        randomWord = $random(seed);
        strobes = 1 + int'(randomWord[1:0]);
        repeat (strobes) begin
            randomWord = $random(seed);
            iOpcode = randomWord[5:0];
            if (iOpcode == `NFC_PROGRAM_COMMAND_ID) begin
                iOpcode = iOpcode ^ 6'h01;
            end
            iCMDValid = 1'b1;
            @(negedge iSystemClock);
        end
        iCMDValid = 1'b0;
    endtask

    task automatic sendProgram(input logic [1:0] planeBits);
        logic [31:0] randomWord;
        while (!oCMDReady) begin
            @(negedge iSystemClock);
        end
        randomWord = $random(seed);
        iTargetID = {randomWord[4:2], planeBits};
        iLength = randomWord[31:16];
        randomWord = $random(seed);
        iColAddress = randomWord[15:0];
        iWaySelect = NumberOfWays'(1) << randomWord[17:16];
        randomWord = $random(seed);
        iRowAddress = randomWord[23:0];
        iOpcode = `NFC_PROGRAM_COMMAND_ID;
        iCMDValid = 1'b1;
        @(negedge iSystemClock);
        iCMDValid = 1'b0;
        // inverted fields while busy so only the latched copy can match
        iTargetID = ~iTargetID;
        iLength = ~iLength;
        iColAddress = ~iColAddress;
        iRowAddress = ~iRowAddress;
        iWaySelect = ~iWaySelect;
        while (!oLastStep) begin
            @(negedge iSystemClock);
        end
        // back to idle
        @(negedge iSystemClock);
    endtask

    // one last-step pulse per submodule request after 1 to 8 cycles
    initial begin : responder
        int          countdown;
        logic [2:0]  pulseBit;
        logic        pending;
        logic [31:0] randomWord;
        iACG_LastStep = 8'h00;
        pending = 1'b0;
        countdown = 0;
        pulseBit = 3'd0;
        forever begin
            @(negedge iSystemClock);
            iACG_LastStep = 8'h00;
            if (!pending && !iReset && oACG_Command != 8'h00) begin
                randomWord = $random(responseSeed);
                countdown = int'(randomWord[2:0]);
                pulseBit = oACG_Command[`NFC_ACG_COMMAND_CA] ? 3'(`NFC_ACG_COMMAND_CA)
                                                            : 3'(`NFC_ACG_COMMAND_DATA);
                pending = 1'b1;
            end
            if (pending) begin
                if (countdown == 0) begin
                    iACG_LastStep[pulseBit] = 1'b1;
                    pending = 1'b0;
                end else begin
                    countdown--;
                end
            end
        end
    end

    always @(posedge iSystemClock) begin
        cycleCount++;
        if (cycleCount == CycleLimit) begin
            timeoutCount++;
            $display("timeout: the commands did not finish within %0d cycles", CycleLimit);
            finishRun();
        end
    end

    initial begin : stimulus
        iReset = 1'b1;
        iOpcode = 6'h00;
        iTargetID = 5'h00;
        iLength = 16'h0000;
        iColAddress = 16'h0000;
        iRowAddress = 24'h000000;
        iCMDValid = 1'b0;
        iWaySelect = '0;
        repeat (8) begin
            @(negedge iSystemClock);
        end
        iReset = 1'b0;
        // plane bits cycle so every confirm opcode shows up
        for (int i = 0; i < CommandCount; i++) begin
            sendWrongStrobes();
            sendProgram(2'(i));
        end
        repeat (4) begin
            @(negedge iSystemClock);
        end
        finishRun();
    end

endmodule

/* all.f */
+incdir+design
design/nfcProgramPkg.sv
design/programCommandLatch.sv
design/programStepSequencer.sv
design/acgRequestBuilder.sv
design/nfcProgramPage.sv
dv/nfcProgramPage_props.sv
dv/tbNfcProgramPage.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbNfcProgramPage
FILELIST = all.f
BUILDDIR = obj_dir
LOG      = sim.log
PASS     = Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# pass or fail comes from the log, not from the exit code of the run
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "^$(PASS)$$" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
